// ==== common/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

  ////////////////////
  // Geometry
  ////////////////////
  localparam int addr_w     = 16;               // CPU byte address
  localparam int word_w     = 16;               // One data word
  localparam int tag_w      = 6;                // Address bits 15..10
  localparam int set_w      = 6;                // Address bits 9..4
  localparam int word_idx_w = 3;                // Address bits 3..1
  localparam int mem_adr_w  = 15;               // Word address seen on the bus
  localparam int meta_w     = tag_w + 2;        // Tag plus valid plus LRU
  localparam int num_sets   = 64;
  localparam int num_ways   = 2;
  localparam int line_words = 8;
  localparam int mem_words  = 32768;            // Whole 64 KB space as 16-bit words

  // Bit positions inside one metadata entry, the tag sits above them
  localparam int meta_valid_bit = 1;
  localparam int meta_lru_bit   = 0;            // Set when this way was used last

  // Memory word at word address a holds a ^ mem_seed
  localparam logic [word_w-1:0] mem_seed = 16'ha5c3;

  typedef logic [word_w-1:0]     word_t;
  typedef logic [addr_w-1:0]     addr_t;
  typedef logic [tag_w-1:0]      tag_t;
  typedef logic [set_w-1:0]      set_idx_t;
  typedef logic [word_idx_w-1:0] word_idx_t;
  typedef logic [mem_adr_w-1:0]  mem_adr_t;
  typedef logic [meta_w-1:0]     meta_t;      // {tag, valid, lru}

  // Controller FSM, one CPU request at a time
  typedef enum logic [2:0] {
    idle,                                       // Wait for req
    lookup,                                     // Tag compare on the latched address
    fill_req,                                   // First cycle of a line fill read
    fill_wait,                                  // Wait for ack of a fill read
    write_req,                                  // First cycle of the write-through
    write_wait,                                 // Wait for ack of the write
    respond                                     // ready pulse toward the CPU
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== common/wb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Wishbone classic link between the cache controller and the backing memory
interface wb_if
  import cache_pkg::*;
();

  logic     cyc;                                // Bus cycle in progress
  logic     stb;                                // Valid transfer request
  logic     we;                                 // High for a write
  mem_adr_t adr;                                // Word address
  word_t    dat_w;                              // Master to slave data
  word_t    dat_r;                              // Slave to master data, valid with ack
  logic     ack;                                // One cycle per transfer

  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );

endinterface

`default_nettype wire

// ==== cache/data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_array
  import cache_pkg::*;
(
  input  logic      clk,
  input  logic      write,                      // Store data into the selected way
  input  logic      way,                        // Way that takes the write
  input  set_idx_t  set,
  input  word_idx_t word,
  input  word_t     data,
  output word_t     data_way0,
  output word_t     data_way1
);

  // Each way is 64 sets of 8 words, addressed as {set, word}
  word_t lines [num_ways][num_sets*line_words];

  logic [set_w+word_idx_w-1:0] row;             // Flat word index inside one way

  assign row = {set, word};

  // Both ways are read every cycle so the core can compare and select
  assign data_way0 = lines[0][row];
  assign data_way1 = lines[1][row];

  ////////////////////
  // Write port
  ////////////////////
  // Only one way is written per edge, validity is tracked in the metadata
  always_ff @(posedge clk) begin
    if (write) begin
      lines[way][row] <= data;
    end
  end

endmodule

`default_nettype wire

// ==== cache/meta_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module meta_data_array
  import cache_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     write,                       // Update both entries of the set
  input  set_idx_t set,
  input  meta_t    meta_in_way0,
  input  meta_t    meta_in_way1,
  output meta_t    meta_way0,
  output meta_t    meta_way1
);

  // One {tag, valid, lru} entry per way per set
  meta_t entries [num_ways][num_sets];

  // Combinational read so the tag compare lands in the lookup cycle
  assign meta_way0 = entries[0][set];
  assign meta_way1 = entries[1][set];

  ////////////////////
  // Update port
  ////////////////////
  // Both ways of a set are written together
  // That is how the LRU flags flip as a pair
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // All lines invalid and way 0 named as LRU in every set
      for (int s = 0; s < num_sets; s++) begin
        entries[0][s] <= '0;
        entries[1][s] <= '0;
      end
    end else if (write) begin
      entries[0][set] <= meta_in_way0;
      entries[1][set] <= meta_in_way1;
    end
  end

endmodule

`default_nettype wire

// ==== cache/cache_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_core
  import cache_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  addr_t     addr,                       // Latched CPU byte address
  input  word_idx_t fill_word,                  // Word being filled while fill is high
  input  word_t     data,                       // Fill word or CPU write data
  input  logic      write_data,                 // Write one word into the data array
  input  logic      update_meta,                // Write new metadata for the set
  input  logic      fill,                       // Line fill in progress
  output word_t     data_out,
  output logic      hit
);

  tag_t      addr_tag;
  set_idx_t  addr_set;
  word_idx_t addr_word;
  word_idx_t array_word;                        // Word index seen by the data array
  meta_t     meta_way0;
  meta_t     meta_way1;
  meta_t     meta_new_way0;
  meta_t     meta_new_way1;
  word_t     data_way0;
  word_t     data_way1;
  logic      match_way0;
  logic      match_way1;
  logic      victim;                            // Way to replace, from current metadata
  logic      victim_q;                          // Victim frozen for the whole fill
  logic      sel_way;                           // Way that takes data and becomes MRU

  assign addr_tag  = addr[15:10];
  assign addr_set  = addr[9:4];
  assign addr_word = addr[3:1];

  ////////////////////
  // Tag compare
  ////////////////////
  assign match_way0 = meta_way0[meta_valid_bit] && (meta_way0[meta_w-1:2] == addr_tag);
  assign match_way1 = meta_way1[meta_valid_bit] && (meta_way1[meta_w-1:2] == addr_tag);
  assign hit        = match_way0 | match_way1;
  assign data_out   = match_way1 ? data_way1 : data_way0;  // Way 0 word on a miss, unused

  // An empty way is taken first
  // Otherwise the way that was not used last is replaced
  assign victim = !meta_way0[meta_valid_bit] ? 1'b0 :
                  !meta_way1[meta_valid_bit] ? 1'b1 :
                  meta_way0[meta_lru_bit];

  // The set stays the same during the fill, but the victim is held so the
  // final metadata write still targets the way the data went into
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      victim_q <= 1'b0;
    end else if (!fill) begin
      victim_q <= victim;
    end
  end

  assign sel_way    = fill ? victim_q : match_way1;  // Victim on fill, hitting way otherwise
  assign array_word = fill ? fill_word : addr_word;

  // Fill installs the tag as valid in the chosen way
  // Both fill and hit make the chosen way MRU and the other way LRU
  assign meta_new_way0 = {(fill && !sel_way) ? addr_tag : meta_way0[meta_w-1:2],
                          meta_way0[meta_valid_bit] | (fill && !sel_way),
                          !sel_way};
  assign meta_new_way1 = {(fill && sel_way) ? addr_tag : meta_way1[meta_w-1:2],
                          meta_way1[meta_valid_bit] | (fill && sel_way),
                          sel_way};

  data_array data_array_i (
    .clk       (clk),
    .write     (write_data),
    .way       (sel_way),
    .set       (addr_set),
    .word      (array_word),
    .data      (data),
    .data_way0 (data_way0),
    .data_way1 (data_way1)
  );

  meta_data_array meta_data_array_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .write        (update_meta),
    .set          (addr_set),
    .meta_in_way0 (meta_new_way0),
    .meta_in_way1 (meta_new_way1),
    .meta_way0    (meta_way0),
    .meta_way1    (meta_way1)
  );

endmodule

`default_nettype wire

// ==== cache/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  req,                            // CPU request, held until ready
  input  logic  we,
  input  addr_t addr,
  input  word_t wdata,
  output word_t rdata,                          // Valid with ready on a read
  output logic  ready,                          // One-cycle completion pulse
  wb_if.master  bus
);

  ctrl_state_t state;
  addr_t       addr_q;
  logic        we_q;
  word_t       wdata_q;
  word_t       rdata_q;
  logic        ready_q;
  word_idx_t   fill_cnt;                        // Next line word to fetch
  logic        fill;
  logic        wr_cycle;                        // Write-through in progress
  logic        last_ack;                        // Ack of word 7 of the fill
  logic        write_data;
  logic        update_meta;
  logic        core_hit;
  word_t       core_data_in;
  word_t       core_data_out;

  assign fill     = (state == fill_req) || (state == fill_wait);
  assign wr_cycle = (state == write_req) || (state == write_wait);
  assign last_ack = fill && bus.ack && (fill_cnt == 3'd7);

  ////////////////////
  // Wishbone master
  ////////////////////
  // stb stays high from word 0 through word 7 of a fill
  assign bus.cyc   = fill | wr_cycle;
  assign bus.stb   = fill | wr_cycle;
  assign bus.we    = wr_cycle;
  assign bus.adr   = fill ? {addr_q[15:4], fill_cnt} : addr_q[15:1];
  assign bus.dat_w = wdata_q;

  // Fill words come straight from the bus, a write hit stores the CPU data
  assign core_data_in = fill ? bus.dat_r : wdata_q;
  assign write_data   = (fill && bus.ack) || (state == lookup && we_q && core_hit);
  assign update_meta  = last_ack || (state == lookup && core_hit);  // Install or LRU flip

  assign rdata = rdata_q;
  assign ready = ready_q;

  ////////////////////
  // FSM
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= idle;
      ready_q  <= 1'b0;
      fill_cnt <= '0;
    end else begin
      ready_q <= 1'b0;                          // Pulse only
      case (state)
        idle: if (req) state <= lookup;
        lookup: begin
          if (we_q) begin
            state <= write_req;                 // Line already updated on a hit
          end else if (core_hit) begin
            ready_q <= 1'b1;
            state   <= respond;
          end else begin
            fill_cnt <= '0;                     // Fill starts at word 0 of the line
            state    <= fill_req;
          end
        end
        fill_req, fill_wait: begin
          if (bus.ack) begin
            fill_cnt <= fill_cnt + 3'd1;
            state    <= last_ack ? lookup : fill_req;  // Re-lookup now hits
          end else begin
            state <= fill_wait;
          end
        end
        write_req, write_wait: begin
          if (bus.ack) begin
            ready_q <= 1'b1;
            state   <= respond;
          end else begin
            state <= write_wait;
          end
        end
        respond: state <= idle;
        default: state <= idle;
      endcase
    end
  end

  // Request fields and read data
  always_ff @(posedge clk) begin
    if (state == idle && req) begin
      addr_q  <= addr;
      we_q    <= we;
      wdata_q <= wdata;
    end
    if (state == lookup && !we_q && core_hit) rdata_q <= core_data_out;
  end

  cache_core cache_core_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .addr        (addr_q),
    .fill_word   (fill_cnt),
    .data        (core_data_in),
    .write_data  (write_data),
    .update_meta (update_meta),
    .fill        (fill),
    .data_out    (core_data_out),
    .hit         (core_hit)
  );

endmodule

`default_nettype wire

// ==== source/main_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_mem
  import cache_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  wb_if.slave  bus
);

  word_t mem [mem_words];
  logic  wait_q;                                // Second cycle of the current strobe
  word_t rd_q;                                  // Read word captured in the first cycle

  // Fixed power-up image
  initial begin
    for (int a = 0; a < mem_words; a++) begin
      mem[a] = word_t'(a) ^ mem_seed;
    end
  end

  ////////////////////
  // One wait state
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wait_q <= 1'b0;
    end else if (bus.ack) begin
      wait_q <= 1'b0;                           // Next address may follow at once
    end else if (bus.cyc && bus.stb) begin
      wait_q <= 1'b1;
    end
  end

  assign bus.ack   = bus.cyc && bus.stb && wait_q;
  assign bus.dat_r = rd_q;

  // Read in the first strobe cycle, write when the ack is given
  always @(posedge clk) begin
    if (bus.cyc && bus.stb && !wait_q) rd_q <= mem[bus.adr];
    if (bus.ack && bus.we) mem[bus.adr] <= bus.dat_w;
  end

endmodule

`default_nettype wire

// ==== source/cache_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  req,                            // CPU request
  input  logic  we,                             // Write when high
  input  addr_t addr,                           // Byte address, bit 0 ignored
  input  word_t wdata,
  output word_t rdata,
  output logic  ready                           // Request done
);

  // Internal bus from the cache to the backing memory
  wb_if wb_bus ();

  cache_ctrl cache_ctrl_i (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .we    (we),
    .addr  (addr),
    .wdata (wdata),
    .rdata (rdata),
    .ready (ready),
    .bus   (wb_bus.master)
  );

  main_mem main_mem_i (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (wb_bus.slave)
  );

endmodule

`default_nettype wire

// ==== dv/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic clk,                             // 50 MHz testbench clock
  output logic rst_n                            // Power-up reset, active low
);

  // 20 ns period, first rising edge at 10 ns
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Held low across the rising edges at 10 ns and 30 ns and released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== dv/cache_subsystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem_tb
  import cache_pkg::*;
();

  localparam int num_tests   = 6;
  localparam int test_cycles = 2000;            // Watchdog budget per test
  localparam int req_limit   = 200;             // Longest wait for one ready

  logic  clk;
  logic  gen_rst_n;                             // Power-up reset from clk_gen
  logic  tb_rst_n;                              // Extra reset pulse for the reset test
  logic  rst_n;
  logic  req;
  logic  we;
  addr_t addr;
  word_t wdata;
  word_t rdata;
  logic  ready;

  word_t    ref_mem [mem_words];                // Expected memory image
  tag_t     mdl_tag [num_sets][num_ways];       // LRU model of the cache contents
  logic     mdl_valid [num_sets][num_ways];
  logic     mdl_lru [num_sets];                 // Way that was used least recently
  integer   seed;
  int       errors;
  int       pass_count;
  int       fail_count;
  set_idx_t set_a;                              // Line of tests 1, 2, 3 and 6
  set_idx_t set_b;                              // LRU test
  set_idx_t set_c;                              // Write miss test

  assign rst_n = gen_rst_n & tb_rst_n;

  clk_gen clk_gen_i (
    .clk   (clk),
    .rst_n (gen_rst_n)
  );

  cache_subsystem cache_subsystem_i (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .we    (we),
    .addr  (addr),
    .wdata (wdata),
    .rdata (rdata),
    .ready (ready)
  );

  ////////////////////
  // Reference model
  ////////////////////
  // Word a of the power-up image is a ^ mem_seed
  initial begin
    for (int a = 0; a < mem_words; a++) ref_mem[a] = word_t'(a) ^ mem_seed;
  end

  function automatic addr_t make_addr(input tag_t t, input set_idx_t s, input word_idx_t w);
    return {t, s, w, 1'b0};                     // Bit 0 of a byte address is unused
  endfunction

  task automatic model_reset();
    for (int s = 0; s < num_sets; s++) begin
      mdl_valid[s][0] = 1'b0;
      mdl_valid[s][1] = 1'b0;
      mdl_lru[s]      = 1'b0;                   // Way 0 is LRU after reset
    end
  endtask

  // Predicts hit or miss and moves the model the way the cache should move
  task automatic model_access(input addr_t a, input logic is_write, output logic exp_hit);
    set_idx_t s;
    tag_t     t;
    logic     way;
    logic     victim;
    s       = a[9:4];
    t       = a[15:10];
    exp_hit = 1'b0;
    way     = 1'b0;
    for (int w = 0; w < num_ways; w++) begin
      if (mdl_valid[s][w] && mdl_tag[s][w] == t) begin
        exp_hit = 1'b1;
        way     = w[0];
      end
    end
    if (exp_hit) begin
      mdl_lru[s] = ~way;                        // The other way becomes LRU
    end else if (!is_write) begin
      victim = !mdl_valid[s][0] ? 1'b0 : !mdl_valid[s][1] ? 1'b1 : mdl_lru[s];
      mdl_tag[s][victim]   = t;
      mdl_valid[s][victim] = 1'b1;
      mdl_lru[s]           = ~victim;
    end                                         // A write miss leaves the cache alone
  endtask

  ////////////////////
  // Checks
  ////////////////////
  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("FAIL %s: expected latency %0d, actual latency %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_hit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s: expected hit %b, actual hit %b", name, exp, act);
      errors++;
    end
  endtask

  ////////////////////
  // CPU port driver
  ////////////////////
  // Latency counts falling edges from the drive until ready is seen high
  task automatic run_access(input logic is_write, input addr_t a, input word_t wd,
                            output word_t rd, output int lat);
    int cycles;
    @(negedge clk);
    req    = 1'b1;
    we     = is_write;
    addr   = a;
    wdata  = wd;
    cycles = 0;
    rd     = '0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!ready && cycles < req_limit);
    if (!ready) begin
      $display("ERROR: the DUT gave no ready within %0d cycles for address %h", req_limit, a);
      errors++;
    end else begin
      rd = rdata;                               // Only valid in the ready cycle
    end
    req = 1'b0;
    we  = 1'b0;
    lat = cycles;
  endtask

  task automatic read_check(input string name, input addr_t a, output int lat);
    logic  exp_hit;
    word_t rd;
    model_access(a, 1'b0, exp_hit);
    run_access(1'b0, a, '0, rd, lat);
    check_word(name, ref_mem[a[15:1]], rd);
    check_hit(name, exp_hit, lat == 2);         // Only a hit answers in two cycles
  endtask

  task automatic write_word(input addr_t a, input word_t d);
    logic  exp_hit;
    word_t rd;
    int    lat;
    model_access(a, 1'b1, exp_hit);
    run_access(1'b1, a, d, rd, lat);
    ref_mem[a[15:1]] = d;                       // Write-through reaches memory
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (errors == err_before) begin
      pass_count++;
      $display("test %s: passed", name);
    end else begin
      fail_count++;
      $display("test %s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////
  task automatic test_read_miss_fill();
    int e0;
    int lat;
    e0 = errors;
    read_check("read_miss_fill", make_addr(6'd1, set_a, word_idx_t'($random(seed))), lat);
    finish_test("read_miss_fill", e0);
  endtask

  task automatic test_read_hit();
    int e0;
    int lat;
    e0 = errors;
    for (int w = 0; w < line_words; w++) begin
      read_check("read_hit", make_addr(6'd1, set_a, word_idx_t'(w)), lat);
      check_latency("read_hit", 2, lat);
    end
    finish_test("read_hit", e0);
  endtask

  task automatic test_write_hit();
    int    e0;
    int    lat;
    addr_t a;
    e0 = errors;
    a  = make_addr(6'd1, set_a, word_idx_t'($random(seed)));
    write_word(a, word_t'($random(seed)));
    read_check("write_hit", a, lat);            // New value from the line
    read_check("write_hit", make_addr(6'd2, set_a, 3'd0), lat);
    read_check("write_hit", make_addr(6'd3, set_a, 3'd0), lat);
    read_check("write_hit", a, lat);            // Evicted, so the value comes from memory
    finish_test("write_hit", e0);
  endtask

  task automatic test_lru_replace();
    int e0;
    int lat;
    e0 = errors;
    read_check("lru_replace", make_addr(6'd4, set_b, 3'd1), lat);  // A
    read_check("lru_replace", make_addr(6'd5, set_b, 3'd2), lat);  // B
    read_check("lru_replace", make_addr(6'd4, set_b, 3'd3), lat);  // A again, B is LRU
    read_check("lru_replace", make_addr(6'd6, set_b, 3'd4), lat);  // C replaces B
    read_check("lru_replace", make_addr(6'd4, set_b, 3'd5), lat);
    read_check("lru_replace", make_addr(6'd5, set_b, 3'd6), lat);
    finish_test("lru_replace", e0);
  endtask

  task automatic test_write_miss();
    int    e0;
    int    lat;
    addr_t a;
    e0 = errors;
    a  = make_addr(6'd7, set_c, word_idx_t'($random(seed)));
    write_word(a, word_t'($random(seed)));
    read_check("write_miss", a, lat);           // Not allocated by the write
    finish_test("write_miss", e0);
  endtask

  task automatic test_reset();
    int    e0;
    int    lat;
    addr_t a;
    e0 = errors;
    a  = make_addr(6'd1, set_a, 3'd3);
    read_check("reset", a, lat);                // Still cached from the write hit test
    @(negedge clk);
    tb_rst_n = 1'b0;
    repeat (2) @(negedge clk);
    tb_rst_n = 1'b1;
    model_reset();
    read_check("reset", a, lat);                // All lines invalid again
    finish_test("reset", e0);
  endtask

  // Ends a run that stalls somewhere inside the tests
  initial begin
    repeat (num_tests * test_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", num_tests * test_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    req        = 1'b0;
    we         = 1'b0;
    addr       = '0;
    wdata      = '0;
    tb_rst_n   = 1'b1;
    errors     = 0;
    pass_count = 0;
    fail_count = 0;
    seed       = 32'h9e1cbf02;
    model_reset();
    set_a = set_idx_t'($random(seed));
    set_b = set_a ^ 6'h2a;                      // Three different sets
    set_c = set_a ^ 6'h15;
    wait (gen_rst_n === 1'b1);
    test_read_miss_fill();
    test_read_hit();
    test_write_hit();
    test_lru_replace();
    test_write_miss();
    test_reset();
    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (errors == 0 && fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cache_subsystem.f ====
common/cache_pkg.sv
common/wb_if.sv
cache/data_array.sv
cache/meta_data_array.sv
cache/cache_core.sv
cache/cache_ctrl.sv
source/main_mem.sv
source/cache_subsystem.sv
dv/clk_gen.sv
dv/cache_subsystem_tb.sv
